// ==== verilog/gfPkg.sv ====
package gfPkg;

	// GF(2^4) built on x^4+x+1
	localparam int GF_M = 4;
	localparam logic [GF_M:0] GF_PRIM = 5'b10011;
	localparam int GF_ORDER = (1 << GF_M) - 1;	// Nonzero elements

	typedef logic [GF_M-1:0] gfElemT;

	// Shift-and-add product, reducing as the multiplicand is doubled
	function automatic gfElemT gfMul(gfElemT a, gfElemT b);
		gfElemT acc;
		gfElemT sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < GF_M; i++) begin
			if (b[i])
				acc ^= sh;
			if (sh[GF_M-1])
				sh = (sh << 1) ^ GF_PRIM[GF_M-1:0];
			else
				sh = sh << 1;
		end
		return acc;
	endfunction

	// alpha^n, exponent taken modulo the group order
	function automatic gfElemT gfAlphaPow(int n);
		gfElemT p;
		int e;
		p = gfElemT'(1);
		e = n % GF_ORDER;
		if (e < 0)
			e += GF_ORDER;
		for (int i = 0; i < GF_ORDER; i++) begin
			if (i < e)
				p = gfMul(p, gfElemT'(2));	// Times alpha
		end
		return p;
	endfunction

endpackage

// ==== verilog/bchPkg.sv ====
package bchPkg;

	// (15,5) binary BCH, three errors
	localparam int BCH_N = 15;
	localparam int BCH_K = 5;
	localparam int BCH_T = 3;

	// One locator iteration per this many cycles
	localparam int BM_STEP_CYCLES = 4;

	// Sampling edge to dout, two slots plus the output register
	localparam int DECODE_LATENCY = 2 * BCH_N + 1;

	// Data buffer covers syndrome and locator slots
	localparam int DELAY_LEN = DECODE_LATENCY - 1;

	// Slots to pass before the first Chien slot
	localparam int WARMUP_SLOTS = DELAY_LEN / BCH_N;

	// Bit position counter values framing vdout
	localparam int VALID_FIRST_POS = DECODE_LATENCY % BCH_N;
	localparam int VALID_LAST_POS = VALID_FIRST_POS + BCH_K - 1;

	// Counter widths
	localparam int POS_W = $clog2(BCH_N);
	localparam int BM_ITER_W = $clog2(BCH_T);
	localparam int BM_STEP_W = $clog2(BM_STEP_CYCLES);

endpackage

// ==== verilog/bchSyndrome.sv ====
`timescale 1ns/1ps

module bchSyndrome
	import gfPkg::*;
	import bchPkg::*;
(
	input  logic   clk,
	input  logic   arstN,
	input  logic   din,
	input  logic   synLoad,
	output gfElemT syn1,
	output gfElemT syn3,
	output gfElemT syn5
);

	// Index k holds S(2k+1)
	gfElemT acc [0:BCH_T-1];
	gfElemT accNext [0:BCH_T-1];
	gfElemT synQ [0:BCH_T-1];

	// Horner step, r(x) arrives highest degree first
	always_comb begin
		for (int k = 0; k < BCH_T; k++) begin
			accNext[k] = gfMul(acc[k], gfAlphaPow(2 * k + 1)) ^ gfElemT'(din);
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int k = 0; k < BCH_T; k++) begin
				acc[k] <= '0;
			end
		end else begin
			for (int k = 0; k < BCH_T; k++) begin
				if (synLoad)
					acc[k] <= '0;	// Next codeword starts clean
				else
					acc[k] <= accNext[k];
			end
		end
	end

	// Last bit is folded in before latching
	always_ff @(posedge clk) begin
		if (synLoad) begin
			for (int k = 0; k < BCH_T; k++) begin
				synQ[k] <= accNext[k];
			end
		end
	end

	assign syn1 = synQ[0];
	assign syn3 = synQ[1];
	assign syn5 = synQ[2];

endmodule

// ==== verilog/bchErrorLocator.sv ====
`timescale 1ns/1ps

module bchErrorLocator
	import gfPkg::*;
	import bchPkg::*;
(
	input  logic   clk,
	input  logic   arstN,
	input  logic   locStart,
	input  gfElemT syn1,
	input  gfElemT syn3,
	input  gfElemT syn5,
	output gfElemT lambda1,
	output gfElemT lambda2,
	output gfElemT lambda3
);

	gfElemT synTab [1:2*BCH_T-1];	// S1 to S5
	gfElemT lam [0:BCH_T];	// Working locator, not normalized
	gfElemT bb [0:BCH_T];	// Correction polynomial
	gfElemT lamNext [0:BCH_T];
	gfElemT gammaQ;	// Last nonzero discrepancy
	gfElemT deltaAcc;
	gfElemT delta;
	gfElemT prod;
	gfElemT synSel;
	gfElemT lamInv;
	int synIdx;
	logic [BM_ITER_W:0] lenL;	// Current LFSR length
	logic busy;
	logic [BM_STEP_W-1:0] step;
	logic [BM_ITER_W-1:0] iter;
	logic lastStep;
	logic lastIter;
	logic doSwap;

	// a^-1 = a^14 = a^2 * a^4 * a^8
	function automatic gfElemT gfInv(gfElemT a);
		gfElemT a2;
		gfElemT a4;
		gfElemT a8;
		a2 = gfMul(a, a);
		a4 = gfMul(a2, a2);
		a8 = gfMul(a4, a4);
		return gfMul(gfMul(a2, a4), a8);
	endfunction

	// Binary code, so S2 = S1^2 and S4 = S2^2
	always_comb begin
		synTab[1] = syn1;
		synTab[2] = gfMul(syn1, syn1);
		synTab[3] = syn3;
		synTab[4] = gfMul(synTab[2], synTab[2]);
		synTab[5] = syn5;
	end

	assign lastStep = (step == BM_STEP_W'(BM_STEP_CYCLES - 1));
	assign lastIter = (iter == BM_ITER_W'(BCH_T - 1));

	always_comb begin
		// One discrepancy term per step, lam[j] * S(2i+1-j)
		synIdx = 2 * int'(iter) + 1 - int'(step);
		if (synIdx >= 1 && synIdx <= 2 * BCH_T - 1)
			synSel = synTab[synIdx];
		else
			synSel = '0;
		prod = gfMul(lam[step], synSel);
		delta = deltaAcc ^ prod;
		doSwap = (delta != '0) && (lenL <= {1'b0, iter});

		// Inversionless update gamma*lam + delta*x*B
		lamNext[0] = gfMul(gammaQ, lam[0]);
		for (int j = 1; j <= BCH_T; j++) begin
			lamNext[j] = gfMul(gammaQ, lam[j]) ^ gfMul(delta, bb[j-1]);
		end
		lamInv = gfInv(lamNext[0]);	// lam0 is a product of nonzero terms
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			busy <= 1'b0;
			step <= '0;
			iter <= '0;
			lenL <= '0;
		end else if (locStart) begin
			busy <= 1'b1;
			step <= '0;
			iter <= '0;
			lenL <= '0;
		end else if (busy) begin
			if (lastStep) begin
				step <= '0;
				if (doSwap)
					lenL <= {iter, 1'b1} - lenL;	// L = 2i+1-L
				if (lastIter) begin
					busy <= 1'b0;
					iter <= '0;
				end else begin
					iter <= iter + 1'b1;
				end
			end else begin
				step <= step + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (locStart) begin
			for (int j = 0; j <= BCH_T; j++) begin
				lam[j] <= (j == 0) ? gfElemT'(1) : '0;
				bb[j] <= (j == 0) ? gfElemT'(1) : '0;
			end
			gammaQ <= gfElemT'(1);
			deltaAcc <= '0;
		end else if (busy) begin
			if (!lastStep) begin
				deltaAcc <= delta;
			end else begin
				deltaAcc <= '0;
				lam <= lamNext;
				bb[0] <= '0;
				if (doSwap) begin
					gammaQ <= delta;
					for (int j = 1; j <= BCH_T; j++) begin
						bb[j] <= lam[j-1];	// x * old lam
					end
				end else begin
					bb[1] <= '0;
					for (int j = 2; j <= BCH_T; j++) begin
						bb[j] <= bb[j-2];	// Even step skipped, x^2
					end
				end
				if (lastIter) begin
					lambda1 <= gfMul(lamNext[1], lamInv);
					lambda2 <= gfMul(lamNext[2], lamInv);
					lambda3 <= gfMul(lamNext[3], lamInv);
				end
			end
		end
	end

endmodule

// ==== verilog/bchChienSearch.sv ====
`timescale 1ns/1ps

module bchChienSearch
	import gfPkg::*;
	import bchPkg::*;
(
	input  logic   clk,
	input  logic   arstN,
	input  logic   chienLoad,
	input  gfElemT lambda1,
	input  gfElemT lambda2,
	input  gfElemT lambda3,
	output logic   errFlag
);

	gfElemT lamIn [1:BCH_T];
	gfElemT term [1:BCH_T];	// lambda_k * x^k at the current position
	gfElemT termSum;

	assign lamIn[1] = lambda1;
	assign lamIn[2] = lambda2;
	assign lamIn[3] = lambda3;

	// Position 14 is tested at x = alpha^-14 = alpha
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int k = 1; k <= BCH_T; k++) begin
				term[k] <= '0;
			end
		end else begin
			for (int k = 1; k <= BCH_T; k++) begin
				if (chienLoad)
					term[k] <= gfMul(lamIn[k], gfAlphaPow(k));
				else
					term[k] <= gfMul(term[k], gfAlphaPow(k));	// Next lower position
			end
		end
	end

	// Root of 1 + l1 x + l2 x^2 + l3 x^3 marks an error
	always_comb begin
		termSum = gfElemT'(1);
		for (int k = 1; k <= BCH_T; k++) begin
			termSum ^= term[k];
		end
	end

	assign errFlag = (termSum == '0);

endmodule

// ==== verilog/bchDecodeControl.sv ====
`timescale 1ns/1ps

module bchDecodeControl
	import bchPkg::*;
(
	input  logic clk,
	input  logic arstN,
	output logic synLoad,
	output logic locStart,
	output logic chienLoad,
	output logic vdout
);

	logic [POS_W-1:0] pos;	// Bit index within the current slot
	logic [1:0] slotCnt;	// Saturates once the pipeline is full
	logic lastBit;
	logic warm;

	assign lastBit = (pos == POS_W'(BCH_N - 1));
	assign warm = (slotCnt == 2'(WARMUP_SLOTS));

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pos <= '0;
			slotCnt <= '0;
			locStart <= 1'b0;
		end else begin
			if (lastBit)
				pos <= '0;
			else
				pos <= pos + 1'b1;

			if (lastBit && !warm)
				slotCnt <= slotCnt + 1'b1;

			locStart <= synLoad;	// Syndromes are stable from here
		end
	end

	// Syndrome boundary every codeword
	assign synLoad = lastBit;

	// No locator result exists before the second boundary
	assign chienLoad = lastBit && (slotCnt != '0);

	// Message bits leave first in each Chien slot
	assign vdout = warm
		&& (pos >= POS_W'(VALID_FIRST_POS))
		&& (pos <= POS_W'(VALID_LAST_POS));

endmodule

// ==== verilog/bchDecoder.sv ====
`timescale 1ns/1ps

module bchDecoder
	import gfPkg::*;
	import bchPkg::*;
(
	input  logic clk,
	input  logic arstN,
	input  logic din,
	output logic vdout,
	output logic dout
);

	logic synLoad;
	logic locStart;
	logic chienLoad;
	logic errFlag;
	gfElemT syn1;
	gfElemT syn3;
	gfElemT syn5;
	gfElemT lambda1;
	gfElemT lambda2;
	gfElemT lambda3;
	logic [DELAY_LEN-1:0] delayLine;	// Two slots of raw bits
	logic doutQ;

	bchDecodeControl uControl (
		.clk       (clk),
		.arstN     (arstN),
		.synLoad   (synLoad),
		.locStart  (locStart),
		.chienLoad (chienLoad),
		.vdout     (vdout)
	);

	bchSyndrome uSyndrome (
		.clk     (clk),
		.arstN   (arstN),
		.din     (din),
		.synLoad (synLoad),
		.syn1    (syn1),
		.syn3    (syn3),
		.syn5    (syn5)
	);

	bchErrorLocator uLocator (
		.clk      (clk),
		.arstN    (arstN),
		.locStart (locStart),
		.syn1     (syn1),
		.syn3     (syn3),
		.syn5     (syn5),
		.lambda1  (lambda1),
		.lambda2  (lambda2),
		.lambda3  (lambda3)
	);

	bchChienSearch uChien (
		.clk       (clk),
		.arstN     (arstN),
		.chienLoad (chienLoad),
		.lambda1   (lambda1),
		.lambda2   (lambda2),
		.lambda3   (lambda3),
		.errFlag   (errFlag)
	);

	// Tail lines up with errFlag of the same position
	always_ff @(posedge clk) begin
		delayLine <= {delayLine[DELAY_LEN-2:0], din};
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			doutQ <= 1'b0;
		else
			doutQ <= delayLine[DELAY_LEN-1] ^ errFlag;	// Flip flagged bit
	end

	assign dout = doutQ & vdout;	// Parity and warm-up bits read as 0

endmodule

// ==== dv/bchDecoderProperties.sv ====
`timescale 1ns/1ps

module bchDecoderProperties
	import bchPkg::*;
(
	input logic clk,
	input logic arstN,
	input logic vdout,
	input logic dout
);

	localparam int GAP = BCH_N - BCH_K;

	int unsigned failCount = 0;
	logic [5:0] edgeCnt;	// Edges since reset, saturating
	logic [4:0] hiCnt;	// Length of the current vdout run
	logic [4:0] loCnt;	// Length of the current gap
	logic seen;	// First run has started

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			edgeCnt <= '0;
			hiCnt <= '0;
			loCnt <= '0;
			seen <= 1'b0;
		end else begin
			if (edgeCnt != '1)
				edgeCnt <= edgeCnt + 1'b1;
			if (vdout) begin
				hiCnt <= hiCnt + 1'b1;
				loCnt <= '0;
				seen <= 1'b1;
			end else begin
				hiCnt <= '0;
				if (loCnt != '1)
					loCnt <= loCnt + 1'b1;
			end
		end
	end

	// Pipeline still filling
	warmupQuiet: assert property (@(posedge clk) disable iff (!arstN)
		(edgeCnt < 6'(DECODE_LATENCY)) |-> !vdout)
		else begin
			$error("vdout went high before the first codeword was decoded");
			failCount++;
		end

	// Run no longer than K, and a new run only after a full gap
	runShape: assert property (@(posedge clk) disable iff (!arstN)
		vdout |-> (hiCnt < 5'(BCH_K)) && (hiCnt != '0 || !seen || loCnt == 5'(GAP)))
		else begin
			$error("vdout run too long or started after a wrong gap");
			failCount++;
		end

	// Run ended at exactly K and gap no longer than N-K
	gapShape: assert property (@(posedge clk) disable iff (!arstN)
		!vdout |-> (hiCnt == '0 || hiCnt == 5'(BCH_K)) && (!seen || loCnt < 5'(GAP)))
		else begin
			$error("vdout run too short or gap too long");
			failCount++;
		end

	doutGated: assert property (@(posedge clk) disable iff (!arstN)
		!vdout |-> !dout)
		else begin
			$error("dout high while vdout is low");
			failCount++;
		end

endmodule

bind bchDecoder bchDecoderProperties uProps (
	.clk   (clk),
	.arstN (arstN),
	.vdout (vdout),
	.dout  (dout)
);

// ==== dv/bchDecoderTb.sv ====
`timescale 1ns/1ps

module bchDecoderTb
	import bchPkg::*;
();

	localparam int NUM_TESTS = 4;
	localparam int CLEAN_WORDS = 8;
	localparam int ERR_WORDS = 12;
	localparam int TOTAL_WORDS = CLEAN_WORDS + 3 * ERR_WORDS;
	localparam int CYCLE_LIMIT = 16 + BCH_N * (TOTAL_WORDS + 3) + 100;
	localparam logic [BCH_N-1:0] GEN_POLY = 15'h0537;	// x^10+x^8+x^5+x^4+x^2+x+1

	logic clk = 1'b0;
	logic arstN;
	logic din;
	logic vdout;
	logic dout;

	logic [15:0] lfsr;
	logic [BCH_N-1:0] txWords [$];	// Codewords with errors applied
	logic expQ [$];	// Message bits in output order
	int testEndBits [NUM_TESTS];
	string testName [NUM_TESTS];
	int testFails [NUM_TESTS] = '{default: 0};
	int curTest = 0;
	int bitsChecked = 0;
	int testsPassed = 0;
	int testsFailed = 0;
	int cycles = 0;
	logic expBit;
	logic allChecked = 1'b0;

	bchDecoder DUT (
		.clk   (clk),
		.arstN (arstN),
		.din   (din),
		.vdout (vdout),
		.dout  (dout)
	);

	always #10 clk = ~clk;

	// Taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic drawBits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	// Message on top, remainder of m(x)*x^10 mod g(x) below
	function automatic logic [BCH_N-1:0] encode(logic [BCH_K-1:0] msg);
		logic [BCH_N-1:0] r;
		r = BCH_N'(msg) << (BCH_N - BCH_K);
		for (int i = BCH_N - 1; i >= BCH_N - BCH_K; i--) begin
			if (r[i])
				r ^= GEN_POLY << (i - (BCH_N - BCH_K));
		end
		return {msg, r[BCH_N-BCH_K-1:0]};
	endfunction

	// Distinct positions until the mask holds n errors
	task automatic addErrors(input int n, inout logic [BCH_N-1:0] mask);
		int pos;
		while ($countones(mask) < n) begin
			drawBits(4, pos);
			if (pos < BCH_N)
				mask[pos] = 1'b1;	// 15 is redrawn
		end
	endtask

	task automatic sendWord(input logic [BCH_K-1:0] msg, input logic [BCH_N-1:0] errMask);
		txWords.push_back(encode(msg) ^ errMask);
		for (int b = BCH_K - 1; b >= 0; b--) begin
			expQ.push_back(msg[b]);
		end
	endtask

	task automatic buildTest(input int t, input int words, input int nErr);
		int msg;
		logic [BCH_N-1:0] mask;
		for (int w = 0; w < words; w++) begin
			drawBits(BCH_K, msg);
			mask = '0;
			if (nErr == BCH_T && w < 2) begin
				msg = (w == 0) ? 0 : (1 << BCH_K) - 1;	// All zeros, then all ones
				mask[0] = 1'b1;
				mask[BCH_N-1] = 1'b1;
			end
			addErrors(nErr, mask);
			sendWord(BCH_K'(msg), mask);
		end
		testEndBits[t] = expQ.size();
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clk) begin
		if (arstN && vdout && !allChecked) begin
			expBit = expQ.pop_front();
			doutMatch: assert (dout === expBit)
				else begin
					$error("error dout expected %h got %h", expBit, dout);
					testFails[curTest]++;
				end
			bitsChecked++;
			if (bitsChecked == testEndBits[curTest]) begin
				$display("test %0d %s: %0d mismatches", curTest + 1, testName[curTest],
					testFails[curTest]);
				if (testFails[curTest] == 0)
					testsPassed++;
				else
					testsFailed++;
				if (curTest == NUM_TESTS - 1)
					allChecked = 1'b1;
				else
					curTest++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: decoder stopped producing output after %0d cycles", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		arstN = 1'b0;
		din = 1'b0;
		lfsr = 16'd23;
		testName[0] = "error-free";
		testName[1] = "single errors";
		testName[2] = "double errors";
		testName[3] = "triple errors";
		buildTest(0, CLEAN_WORDS, 0);
		for (int t = 1; t < NUM_TESTS; t++) begin
			buildTest(t, ERR_WORDS, t);
		end

		repeat (16) @(posedge clk);
		arstN <= 1'b1;

		// Back to back, first bit on the edge after reset release
		foreach (txWords[w]) begin
			for (int b = BCH_N - 1; b >= 0; b--) begin
				din <= txWords[w][b];
				@(posedge clk);
			end
		end
		din <= 1'b0;

		while (!allChecked)
			@(posedge clk);

		$display("test 5 back-to-back framing: %0d assertion failures", DUT.uProps.failCount);
		if (DUT.uProps.failCount == 0)
			testsPassed++;
		else
			testsFailed++;

		$display("tests passed %0d, failed %0d", testsPassed, testsFailed);
		if (testsFailed == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
verilog/gfPkg.sv
verilog/bchPkg.sv
verilog/bchSyndrome.sv
verilog/bchErrorLocator.sv
verilog/bchChienSearch.sv
verilog/bchDecodeControl.sv
verilog/bchDecoder.sv
dv/bchDecoderProperties.sv
dv/bchDecoderTb.sv

// ==== Makefile ====
# Verilator build and run of the BCH (15,5) decoder testbench

TOP := bchDecoderTb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 2>&1 | tee $(LOG)
	@if grep -q -F '>>> FAIL' $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q -F '>>> PASS' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
